// ==== hw/jtag_ctrl_pkg.sv ====
`default_nettype none

package jtag_ctrl_pkg;

    // Bit counter width, one byte per transfer.
    localparam int BIT_CNT_W = 3;

    // Transfer sequence of the loader.
    typedef enum logic [2:0] {
        IDLE         = 3'd0, // Host owns the chain.
        ENABLE       = 3'd1, // Take over the chain.
        DELAY        = 3'd2, // Power-up wait, control line low.
        CLK_LOW      = 3'd3, // TCK low phase of a bit.
        CLK_HIGH     = 3'd4, // TCK high phase of a bit.
        FINISH_LOW_0 = 3'd5, // Trailing low phase, release control line.
        FINISH_LOW_1 = 3'd6, // Power-down wait.
        END_ENABLE   = 3'd7  // Hand the chain back.
    } shift_state_e;

endpackage : jtag_ctrl_pkg

`default_nettype wire

// ==== hw/jtag_drive_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Forced pin values from the transfer FSM towards the pad stage.
interface jtag_drive_if;

    logic force_en;  // Transfer owns the chain.
    logic tck;       // Forced TCK level.
    logic tdi;       // Forced TDI level.
    logic jctrl_low; // Pull the control line low.

    modport shifter (
        output force_en,
        output tck,
        output tdi,
        output jctrl_low
    );

    modport pins (
        input force_en,
        input tck,
        input tdi,
        input jctrl_low
    );

endinterface : jtag_drive_if

`default_nettype wire

// ==== hw/clk_div_ce.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_div_ce #(
    parameter logic [31:0] CLK_DIVIDE = 32'd31
) (
    input  wire  clk,
    input  wire  arst_n_i,
    output logic ce_o
);

    localparam logic [31:0] RELOAD = CLK_DIVIDE - 32'd1;

    logic [31:0] cnt_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= RELOAD;
        end else if (cnt_q == 32'd0) begin
            cnt_q <= RELOAD; // Wrap, one enable per period.
        end else begin
            cnt_q <= cnt_q - 32'd1;
        end
    end

    // Pulse on the zero count.
    assign ce_o = (cnt_q == 32'd0);

endmodule : clk_div_ce

`default_nettype wire

// ==== hw/term_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_counter #(
    parameter logic [31:0] DELAY_CYCLES = 32'd1000
) (
    input  wire  clk,
    input  wire  arst_n_i,
    input  logic count_i,
    output logic tcount_o
);

    logic [31:0] cnt_q;
    logic        at_limit;

    assign at_limit = (cnt_q == DELAY_CYCLES);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= 32'd0;
        end else if (!count_i) begin
            cnt_q <= 32'd0; // Any gap restarts the wait.
        end else if (!at_limit) begin
            cnt_q <= cnt_q + 32'd1;
        end
    end

    // Saturates at the limit, so the flag holds until count_i drops.
    assign tcount_o = count_i && at_limit;

endmodule : term_counter

`default_nettype wire

// ==== hw/jtag_ctrl_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_shifter (
    input  wire          clk,
    input  wire          arst_n_i,
    input  logic         load_i,
    input  logic [7:0]   dat_i,
    input  logic         ce_i,
    input  logic         delay_done_i,
    output logic         busy_o,
    output logic         delay_count_o,
    jtag_drive_if.shifter drv
);

    import jtag_ctrl_pkg::*;

    shift_state_e         state_q;
    shift_state_e         state_d;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic [7:0]           shift_q;
    logic                 force_q;
    logic                 jctrl_low_q;
    logic                 last_bit;
    logic                 bit_step;

    assign last_bit = (bit_cnt_q == {BIT_CNT_W{1'b1}});
    assign bit_step = (state_q == CLK_HIGH) && ce_i; // End of a bit.

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load_i) begin
                    state_d = ENABLE;
                end
            end
            ENABLE: begin
                state_d = DELAY;
            end
            DELAY: begin
                if (delay_done_i) begin
                    state_d = CLK_LOW;
                end
            end
            CLK_LOW: begin
                if (ce_i) begin
                    state_d = CLK_HIGH;
                end
            end
            CLK_HIGH: begin
                if (ce_i) begin
                    state_d = last_bit ? FINISH_LOW_0 : CLK_LOW;
                end
            end
            FINISH_LOW_0: begin
                if (ce_i) begin
                    state_d = FINISH_LOW_1;
                end
            end
            FINISH_LOW_1: begin
                if (delay_done_i) begin
                    state_d = END_ENABLE;
                end
            end
            END_ENABLE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            bit_cnt_q   <= '0;
            force_q     <= 1'b0;
            jctrl_low_q <= 1'b0;
        end else begin
            state_q <= state_d;

            if (state_q == IDLE) begin
                bit_cnt_q <= '0;
            end else if (bit_step) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end

            if (state_q == ENABLE) begin
                force_q <= 1'b1;
            end else if (state_q == END_ENABLE) begin
                force_q <= 1'b0;
            end

            if (state_q == DELAY) begin
                jctrl_low_q <= 1'b1;
            end else if (state_q == FINISH_LOW_0) begin
                jctrl_low_q <= 1'b0;
            end
        end
    end

    // MSB first, the target shifts upward.
    always_ff @(posedge clk) begin
        if (state_q == IDLE && load_i) begin
            shift_q <= dat_i;
        end else if (bit_step) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign busy_o        = (state_q != IDLE);
    assign delay_count_o = (state_q == DELAY) || (state_q == FINISH_LOW_1);

    assign drv.force_en  = force_q;
    assign drv.tck       = (state_q == CLK_HIGH);
    assign drv.tdi       = shift_q[7];
    assign drv.jctrl_low = jctrl_low_q;

endmodule : jtag_ctrl_shifter

`default_nettype wire

// ==== hw/jtag_pin_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_pin_mux (
    input  wire        clk,
    input  wire        arst_n_i,
    input  logic       tck_i,
    input  logic       tms_i,
    input  logic       tdi_i,
    input  logic       tdo_i,
    input  logic       jtag_enable_i,
    output logic       tck_o,
    output logic       tms_o,
    output logic       tdi_o,
    output logic       tdo_o,
    output logic       jtag_en_o,
    output logic       jctrl_low_o,
    jtag_drive_if.pins drv
);

    logic tck_mux;
    logic tms_mux;
    logic tdi_mux;
    logic tdo_q;

    assign tck_mux = drv.force_en ? drv.tck : tck_i;
    assign tms_mux = drv.force_en ? 1'b1 : tms_i; // TMS parked high while loading.
    assign tdi_mux = drv.force_en ? drv.tdi : tdi_i;

    // Pad flops.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tck_o       <= 1'b0;
            tms_o       <= 1'b0;
            tdi_o       <= 1'b0;
            tdo_q       <= 1'b0;
            jctrl_low_o <= 1'b0;
        end else begin
            tck_o       <= tck_mux;
            tms_o       <= tms_mux;
            tdi_o       <= tdi_mux;
            tdo_q       <= tdo_i;
            jctrl_low_o <= drv.jctrl_low;
        end
    end

    // Host sees nothing from the target during a load.
    assign tdo_o     = drv.force_en ? 1'b0 : tdo_q;
    assign jtag_en_o = drv.force_en || jtag_enable_i;

endmodule : jtag_pin_mux

`default_nettype wire

// ==== hw/jtag_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_top #(
    parameter logic [31:0] CLK_DIVIDE   = 32'd31,
    parameter logic [31:0] DELAY_CYCLES = 32'd1000
) (
    input  wire        clk,
    input  wire        arst_n_i,
    input  logic       load_i,
    input  logic [7:0] dat_i,
    input  logic       jtag_enable_i,
    input  logic       host_tck_i,
    input  logic       host_tms_i,
    input  logic       host_tdi_i,
    output logic       busy_o,
    output logic       host_tdo_o,
    output logic       jtag_en_o,
    output logic       tgt_tck_o,
    output logic       tgt_tms_o,
    output logic       tgt_tdi_o,
    output logic       jctrl_low_o, // Drives the external open-drain buffer.
    input  logic       tgt_tdo_i
);

    logic ce;
    logic delay_count;
    logic delay_done;

    jtag_drive_if drv_if ();

    clk_div_ce #(
        .CLK_DIVIDE (CLK_DIVIDE)
    ) u_div (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ce_o     (ce)
    );

    term_counter #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) u_delay (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .count_i  (delay_count),
        .tcount_o (delay_done)
    );

    jtag_ctrl_shifter u_shift (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .load_i        (load_i),
        .dat_i         (dat_i),
        .ce_i          (ce),
        .delay_done_i  (delay_done),
        .busy_o        (busy_o),
        .delay_count_o (delay_count),
        .drv           (drv_if.shifter)
    );

    jtag_pin_mux u_pins (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .tck_i         (host_tck_i),
        .tms_i         (host_tms_i),
        .tdi_i         (host_tdi_i),
        .tdo_i         (tgt_tdo_i),
        .jtag_enable_i (jtag_enable_i),
        .tck_o         (tgt_tck_o),
        .tms_o         (tgt_tms_o),
        .tdi_o         (tgt_tdi_o),
        .tdo_o         (host_tdo_o),
        .jtag_en_o     (jtag_en_o),
        .jctrl_low_o   (jctrl_low_o),
        .drv           (drv_if.pins)
    );

endmodule : jtag_ctrl_top

`default_nettype wire

// ==== dv/jtag_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_tb;

    import jtag_ctrl_pkg::*;

    localparam logic [31:0] CLK_DIVIDE   = 32'd3;
    localparam logic [31:0] DELAY_CYCLES = 32'd12;
    localparam int          ROWS         = 6;
    localparam int          IDLE_CYCLES  = 16;
    localparam int          TIMEOUT      = ROWS * (2 * DELAY_CYCLES + 20 * CLK_DIVIDE + 40) + 200;
    localparam int unsigned SEED         = 32'haf73_f267;

    typedef struct packed {
        logic [7:0] dat;
        logic       en;     // Host jtag_enable_i during the row.
        logic       inject; // Second load_i while busy.
    } row_t;

    logic       clk;
    logic       arst_n_i;
    logic       load_i;
    logic [7:0] dat_i;
    logic       jtag_enable_i;
    logic       host_tck_i;
    logic       host_tms_i;
    logic       host_tdi_i;
    logic       tgt_tdo_i;
    logic       busy_o;
    logic       host_tdo_o;
    logic       jtag_en_o;
    logic       tgt_tck_o;
    logic       tgt_tms_o;
    logic       tgt_tdi_o;
    logic       jctrl_low_o;

    row_t        rows [ROWS];
    int          cycle_cnt;
    int          edge_total;
    int          start_edges;
    int          busy_cycles;
    logic [7:0]  rx_shift;
    logic        tck_prev;
    logic        last_jlow;

    jtag_ctrl_top #(
        .CLK_DIVIDE   (CLK_DIVIDE),
        .DELAY_CYCLES (DELAY_CYCLES)
    ) u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .load_i        (load_i),
        .dat_i         (dat_i),
        .jtag_enable_i (jtag_enable_i),
        .host_tck_i    (host_tck_i),
        .host_tms_i    (host_tms_i),
        .host_tdi_i    (host_tdi_i),
        .busy_o        (busy_o),
        .host_tdo_o    (host_tdo_o),
        .jtag_en_o     (jtag_en_o),
        .tgt_tck_o     (tgt_tck_o),
        .tgt_tms_o     (tgt_tms_o),
        .tgt_tdi_o     (tgt_tdi_o),
        .jctrl_low_o   (jctrl_low_o),
        .tgt_tdo_i     (tgt_tdo_i)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            abort_run($sformatf("error %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("error %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_state(input string name, input shift_state_e exp,
                               input shift_state_e got);
        if (got !== exp) begin
            abort_run($sformatf("error %s exp %h got %h", name, exp, got));
        end
    endtask

    // Random host traffic while the chain is idle.
    task automatic pass_through(input logic en);
        logic [3:0] v;
        logic [3:0] v_prev;
        v_prev = '0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
            v = 4'($urandom);
            host_tck_i    <= v[0];
            host_tms_i    <= v[1];
            host_tdi_i    <= v[2];
            tgt_tdo_i     <= v[3];
            jtag_enable_i <= en;
            @(negedge clk);
            if (i > 0) begin // Pad flops show last cycle's drive.
                check_bit("tgt_tck_o", v_prev[0], tgt_tck_o);
                check_bit("tgt_tms_o", v_prev[1], tgt_tms_o);
                check_bit("tgt_tdi_o", v_prev[2], tgt_tdi_o);
                check_bit("host_tdo_o", v_prev[3], host_tdo_o);
            end
            check_bit("jtag_en_o", en, jtag_en_o);
            v_prev = v;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run("timeout: transfer never finished");
        end
    end

    // Pin monitor samples one bit per rising TCK while busy.
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (busy_o && tgt_tck_o && !tck_prev) begin
                check_bit("jtag_en_o", 1'b1, jtag_en_o);
                check_bit("tgt_tms_o", 1'b1, tgt_tms_o);
                check_bit("jctrl_low_o", 1'b1, jctrl_low_o);
                rx_shift   <= {rx_shift[6:0], tgt_tdi_o};
                edge_total <= edge_total + 1;
            end
            tck_prev <= tgt_tck_o;
        end
    end

    initial begin
        void'($urandom(SEED));
        cycle_cnt     = 0;
        edge_total    = 0;
        rx_shift      = '0;
        tck_prev      = 1'b0;
        arst_n_i      = 1'b0;
        load_i        = 1'b0;
        dat_i         = '0;
        jtag_enable_i = 1'b0;
        host_tck_i    = 1'b0;
        host_tms_i    = 1'b0;
        host_tdi_i    = 1'b0;
        tgt_tdo_i     = 1'b0;

        rows[0] = '{dat: 8'hA5, en: 1'b1, inject: 1'b1};
        rows[1] = '{dat: 8'h00, en: 1'b0, inject: 1'b0};
        rows[2] = '{dat: 8'hFF, en: 1'b0, inject: 1'b1};
        rows[3] = '{dat: 8'h3C, en: 1'b1, inject: 1'b0};
        rows[4] = '{dat: 8'h81, en: 1'b0, inject: 1'b1};
        rows[5] = '{dat: 8'($urandom), en: 1'b1, inject: 1'b0};

        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("jtag_en_o", 1'b0, jtag_en_o);
        check_bit("jctrl_low_o", 1'b0, jctrl_low_o);
        check_bit("tgt_tck_o", 1'b0, tgt_tck_o);
        check_bit("tgt_tms_o", 1'b0, tgt_tms_o);
        check_bit("tgt_tdi_o", 1'b0, tgt_tdi_o);
        check_state("state_q", IDLE, u_dut.u_shift.state_q);

        for (int r = 0; r < ROWS; r++) begin
            pass_through(rows[r].en);
            start_edges = edge_total;
            @(posedge clk);
            load_i     <= 1'b1;
            dat_i      <= rows[r].dat;
            host_tck_i <= 1'b0; // Quiet host so no stray TCK edge.
            host_tms_i <= 1'b0;
            host_tdi_i <= 1'b0;
            tgt_tdo_i  <= 1'b1; // Makes the TDO mask visible.
            @(posedge clk);
            load_i <= 1'b0;
            dat_i  <= ~rows[r].dat;
            @(negedge clk);
            if (!busy_o) begin
                abort_run("busy_o did not rise after load_i");
            end
            busy_cycles = 0;
            last_jlow   = 1'b1;
            while (busy_o) begin
                busy_cycles++;
                if (busy_cycles > 1) begin // Chain is forced after ENABLE.
                    check_bit("jtag_en_o", 1'b1, jtag_en_o);
                    check_bit("host_tdo_o", 1'b0, host_tdo_o);
                end
                last_jlow = jctrl_low_o;
                @(posedge clk);
                load_i <= rows[r].inject && (busy_cycles == 3);
                @(negedge clk);
            end
            check_bit("jctrl_low_o", 1'b0, last_jlow);
            check_byte("tck_edges", 8'd8, 8'(edge_total - start_edges));
            check_byte("rx_byte", rows[r].dat, rx_shift);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule : jtag_ctrl_tb

`default_nettype wire

// ==== files.f ====
hw/jtag_ctrl_pkg.sv
hw/jtag_drive_if.sv
hw/clk_div_ce.sv
hw/term_counter.sv
hw/jtag_ctrl_shifter.sv
hw/jtag_pin_mux.sv
hw/jtag_ctrl_top.sv
dv/jtag_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module jtag_ctrl_tb -f files.f -o jtag_ctrl_sim \
    && ./obj_dir/jtag_ctrl_sim > sim.log 2>&1 \
    || echo "simulation returned an error status" >> sim.log
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
